//--- dv/mem_pipe_golden.txt
// preload block: one hex word per line for addresses 0 to 7
// op lines: //> mem_op amo_op addr rs2 rd flush exp_rd_we exp_data (mem_op 0 load 1 store 2 amo)
// amo_op 0 swap 1 add 2 and 3 or 4 xor 5 min 6 max 7 minu 8 maxu
00000011
12345678
ffff0000
0000ffff
80000000
7fffffff
fffffff0
00000005
//> 0 0 00 00000000 01 0 1 00000011
//> 0 0 01 00000000 02 0 1 12345678
//> 1 0 08 deadbeef 00 0 0 00000000
//> 0 0 08 00000000 03 0 1 deadbeef
//> 2 0 02 0000aaaa 04 0 1 ffff0000
//> 2 1 03 00000001 05 0 1 0000ffff
//> 2 2 02 0000ff00 06 0 1 0000aaaa
//> 2 3 03 0000000f 07 0 1 00010000
//> 2 4 01 ffffffff 08 0 1 12345678
//> 2 5 04 00000001 09 0 1 80000000
//> 2 7 04 00000001 0a 0 1 80000000
//> 2 6 06 00000003 0b 0 1 fffffff0
//> 2 8 05 80000000 0c 0 1 7fffffff
//> 0 0 02 00000000 0d 0 1 0000aa00
//> 0 0 03 00000000 0e 0 1 0001000f
//> 0 0 01 00000000 0f 0 1 edcba987
//> 0 0 04 00000000 10 0 1 00000001
//> 0 0 06 00000000 11 0 1 00000003
//> 0 0 05 00000000 12 0 1 80000000
//> 2 1 07 00000003 13 0 1 00000005
//> 2 1 07 00000010 14 0 1 00000008
//> 2 0 07 00000100 00 0 0 00000018
//> 0 0 07 00000000 15 0 1 00000100
//> 1 0 00 cafef00d 00 1 0 00000000
//> 2 0 01 00000000 16 1 0 00000000
//> 0 0 00 00000000 17 0 1 00000011
//> 0 0 01 00000000 18 0 1 edcba987
//> 1 0 09 12121212 1a 0 0 00000000
//> 0 0 00 00000000 00 0 0 00000011

//--- mem_pipe_top.f
+incdir+hw
hw/mem_pipe_pkg.sv
hw/stage_memory1.sv
hw/data_mem.sv
hw/stage_memory2.sv
hw/mem_pipe_top.sv
dv/tb_clkgen.sv
dv/mem_pipe_tb.sv

//--- Bender.yml
package:
  name: mem_pipe

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/mem_pipe_pkg.sv
      - hw/stage_memory1.sv
      - hw/data_mem.sv
      - hw/stage_memory2.sv
      - hw/mem_pipe_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - dv/tb_clkgen.sv
      - dv/mem_pipe_tb.sv

//--- dv/mem_pipe_tb.sv
// Memory pipeline testbench
`timescale 1ns/1ps
`include "mem_pipe_consts.svh"

module mem_pipe_tb;

    import mem_pipe_pkg::*;

    localparam GOLDEN_FILE = "dv/mem_pipe_golden.txt";

    logic                        clk;
    logic                        rst_n;
    logic                        stall;
    logic                        flush;
    logic                        in_valid;
    mem_op_e                     in_mem_op;
    amo_op_e                     in_amo_op;
    logic [`MEM_PIPE_ADDR_W-1:0] in_addr;
    word_t                       in_rs2_val;
    logic [4:0]                  in_rd_idx;
    logic                        wb_valid;
    logic [4:0]                  wb_rd_idx;
    logic                        wb_rd_we;
    word_t                       wb_data;

    // operation fields as read from the golden file
    logic [31:0] op_mem_q [$];
    logic [31:0] op_amo_q [$];
    logic [31:0] op_addr_q [$];
    logic [31:0] op_rs2_q [$];
    logic [31:0] op_rd_q [$];
    logic [31:0] op_flush_q [$];
    logic [31:0] op_we_q [$];
    logic [31:0] op_data_q [$];

    // results still owed by the DUT with the oldest first
    string       exp_name_q [$];
    logic [31:0] exp_rd_q [$];
    logic [31:0] exp_we_q [$];
    logic [31:0] exp_data_q [$];
    int          flush_edge_q [$]; // edge numbers that close a flushed op's stage 2 cycle

    logic [31:0] lfsr;
    int          op_idx;
    int          adv_cnt;          // rising edges that were not stalled
    int          cycle_cnt = 0;
    int          cycle_limit = 50;

    tb_clkgen u_clkgen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    mem_pipe_top DUT (
        .clk        (clk),
        .rst_n      (rst_n),
        .stall      (stall),
        .flush      (flush),
        .in_valid   (in_valid),
        .in_mem_op  (in_mem_op),
        .in_amo_op  (in_amo_op),
        .in_addr    (in_addr),
        .in_rs2_val (in_rs2_val),
        .in_rd_idx  (in_rd_idx),
        .wb_valid   (wb_valid),
        .wb_rd_idx  (wb_rd_idx),
        .wb_rd_we   (wb_rd_we),
        .wb_data    (wb_data)
    );

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("*** FAILED ***");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input string field,
                               input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp) else begin
            fail_now($sformatf("mismatch %s %s: expected %h, actual %h", name, field, exp, act));
        end
    endtask

    // Galois form with taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        if (state[0]) begin
            return (state >> 1) ^ 32'h8020_0003;
        end
        return state >> 1;
    endfunction

    task automatic take_bit(output logic b);
        lfsr = lfsr_next(lfsr);
        b = lfsr[0];
    endtask

    task automatic load_golden();
        int          fd;
        int          fields;
        string       line;
        logic [31:0] f_op;
        logic [31:0] f_amo;
        logic [31:0] f_addr;
        logic [31:0] f_rs2;
        logic [31:0] f_rd;
        logic [31:0] f_fl;
        logic [31:0] f_we;
        logic [31:0] f_data;
        fd = $fopen(GOLDEN_FILE, "r");
        assert (fd != 0) else begin
            fail_now("the golden file could not be opened");
        end
        while (!$feof(fd)) begin
            line = "";
            if ($fgets(line, fd) != 0) begin
                // only lines marked //> carry an operation
                fields = $sscanf(line, "//> %h %h %h %h %h %h %h %h",
                                 f_op, f_amo, f_addr, f_rs2, f_rd, f_fl, f_we, f_data);
                if (fields == 8) begin
                    op_mem_q.push_back(f_op);
                    op_amo_q.push_back(f_amo);
                    op_addr_q.push_back(f_addr);
                    op_rs2_q.push_back(f_rs2);
                    op_rd_q.push_back(f_rd);
                    op_flush_q.push_back(f_fl);
                    op_we_q.push_back(f_we);
                    op_data_q.push_back(f_data);
                end
            end
        end
        $fclose(fd);
    endtask

    // one cycle of stimulus applied on the falling edge
    task automatic drive_cycle();
        logic b0;
        logic b1;
        int   next_edge;
        take_bit(b0);
        take_bit(b1);
        next_edge = adv_cnt + 1;
        stall = b0 & b1; // roughly one cycle in four
        flush = 1'b0;
        if (!stall && flush_edge_q.size() > 0 && flush_edge_q[0] == next_edge) begin
            flush = 1'b1;
            void'(flush_edge_q.pop_front());
        end
        if (op_idx < op_mem_q.size()) begin
            in_valid   = 1'b1; // held unchanged while stalled
            in_mem_op  = mem_op_e'(op_mem_q[op_idx][1:0]);
            in_amo_op  = amo_op_e'(op_amo_q[op_idx][3:0]);
            in_addr    = op_addr_q[op_idx][`MEM_PIPE_ADDR_W-1:0];
            in_rs2_val = op_rs2_q[op_idx];
            in_rd_idx  = op_rd_q[op_idx][4:0];
            if (!stall) begin
                if (op_flush_q[op_idx] != 0) begin
                    flush_edge_q.push_back(next_edge + 2);
                end else begin
                    exp_name_q.push_back($sformatf("op %0d", op_idx + 1));
                    exp_rd_q.push_back(op_rd_q[op_idx]);
                    exp_we_q.push_back(op_we_q[op_idx]);
                    exp_data_q.push_back(op_data_q[op_idx]);
                end
                op_idx++;
            end
        end else begin
            in_valid = 1'b0;
        end
        if (!stall) begin
            adv_cnt = next_edge;
        end
    endtask

    initial begin
        stall      = 1'b0;
        flush      = 1'b0;
        in_valid   = 1'b0;
        in_mem_op  = MEM_OP_LOAD;
        in_amo_op  = AMO_OP_SWAP;
        in_addr    = '0;
        in_rs2_val = '0;
        in_rd_idx  = '0;
        lfsr       = 32'hcbbb780e;
        op_idx     = 0;
        adv_cnt    = 0;
        load_golden();
        assert (op_mem_q.size() > 0) else begin
            fail_now("the golden file holds no operation lines");
        end
        cycle_limit = 4 * op_mem_q.size() + 50;
        $readmemh(GOLDEN_FILE, DUT.u_dmem.mem_array); // op lines are comments to readmemh
        wait (rst_n === 1'b1);
        while (op_idx < op_mem_q.size() || flush_edge_q.size() > 0) begin
            @(negedge clk);
            drive_cycle();
        end
        @(negedge clk);
        stall    = 1'b0;
        flush    = 1'b0;
        in_valid = 1'b0;
        repeat (4) @(negedge clk); // two edges drain the pipe and any late extra result shows up
        if (exp_data_q.size() != 0) begin
            fail_now("results are missing at the end of the run");
        end else begin
            $display("*** PASSED ***");
            $finish;
        end
    end

    // every write-back is matched against the oldest expected result
    always @(posedge clk) begin
        if (rst_n === 1'b1 && wb_valid === 1'b1) begin
            assert (exp_data_q.size() > 0) else begin
                fail_now("a result appeared with no operation outstanding");
            end
            check_value(exp_name_q[0], "rd_idx", exp_rd_q[0], {27'd0, wb_rd_idx});
            check_value(exp_name_q[0], "rd_we", exp_we_q[0], {31'd0, wb_rd_we});
            check_value(exp_name_q[0], "data", exp_data_q[0], wb_data);
            void'(exp_name_q.pop_front());
            void'(exp_rd_q.pop_front());
            void'(exp_we_q.pop_front());
            void'(exp_data_q.pop_front());
        end
    end

    always @(posedge clk) begin
        cycle_cnt++;
        assert (cycle_cnt <= cycle_limit) else begin
            fail_now($sformatf("timeout after %0d cycles with results outstanding", cycle_cnt));
        end
    end

endmodule : mem_pipe_tb

//--- dv/tb_clkgen.sv
// Testbench clock and reset
`timescale 1ns/1ps

module tb_clkgen (
    output logic clk,
    output logic rst_n
);

    // 10 ns period
    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    // reset is held over three rising edges and released on a falling edge
    initial begin
        rst_n = 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule : tb_clkgen

//--- hw/mem_pipe_top.sv
// Memory pipeline top level
`timescale 1ns/1ps
`include "mem_pipe_consts.svh"

module mem_pipe_top (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          stall,
    input  logic                          flush,

    input  logic                          in_valid,
    input  mem_pipe_pkg::mem_op_e         in_mem_op,
    input  mem_pipe_pkg::amo_op_e         in_amo_op,
    input  logic [`MEM_PIPE_ADDR_W-1:0]   in_addr,
    input  mem_pipe_pkg::word_t           in_rs2_val,
    input  logic [4:0]                    in_rd_idx,

    output logic                          wb_valid,
    output logic [4:0]                    wb_rd_idx,
    output logic                          wb_rd_we,
    output mem_pipe_pkg::word_t           wb_data
);

    import mem_pipe_pkg::*;

    // stage 1 to stage 2
    logic                        m1_valid;
    mem_op_e                     m1_mem_op;
    amo_op_e                     m1_amo_op;
    logic [`MEM_PIPE_ADDR_W-1:0] m1_addr;
    word_t                       m1_rs2_val;
    logic [4:0]                  m1_rd_idx;

    // memory ports
    logic [`MEM_PIPE_ADDR_W-1:0] rd_addr;
    word_t                       mem_rdata;
    logic                        wr_en;
    logic [`MEM_PIPE_ADDR_W-1:0] wr_addr;
    word_t                       wr_data;

    stage_memory1 u_stage1 (
        .clk        (clk),
        .rst_n      (rst_n),
        .stall      (stall),
        .in_valid   (in_valid),
        .in_mem_op  (in_mem_op),
        .in_amo_op  (in_amo_op),
        .in_addr    (in_addr),
        .in_rs2_val (in_rs2_val),
        .in_rd_idx  (in_rd_idx),
        .m1_valid   (m1_valid),
        .m1_mem_op  (m1_mem_op),
        .m1_amo_op  (m1_amo_op),
        .m1_addr    (m1_addr),
        .m1_rs2_val (m1_rs2_val),
        .m1_rd_idx  (m1_rd_idx),
        .rd_addr    (rd_addr)
    );

    data_mem u_dmem (
        .clk     (clk),
        .rd_addr (rd_addr),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .rd_data (mem_rdata)
    );

    stage_memory2 u_stage2 (
        .clk        (clk),
        .rst_n      (rst_n),
        .stall      (stall),
        .flush      (flush),
        .m1_valid   (m1_valid),
        .m1_mem_op  (m1_mem_op),
        .m1_amo_op  (m1_amo_op),
        .m1_addr    (m1_addr),
        .m1_rs2_val (m1_rs2_val),
        .m1_rd_idx  (m1_rd_idx),
        .mem_rdata  (mem_rdata),
        .wr_en      (wr_en),
        .wr_addr    (wr_addr),
        .wr_data    (wr_data),
        .wb_valid   (wb_valid),
        .wb_rd_idx  (wb_rd_idx),
        .wb_rd_we   (wb_rd_we),
        .wb_data    (wb_data)
    );

endmodule : mem_pipe_top

//--- hw/stage_memory2.sv
// Memory stage 2 with AMO unit
`timescale 1ns/1ps
`include "mem_pipe_consts.svh"

module stage_memory2 (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          stall,
    input  logic                          flush,

    input  logic                          m1_valid,
    input  mem_pipe_pkg::mem_op_e         m1_mem_op,
    input  mem_pipe_pkg::amo_op_e         m1_amo_op,
    input  logic [`MEM_PIPE_ADDR_W-1:0]   m1_addr,
    input  mem_pipe_pkg::word_t           m1_rs2_val,
    input  logic [4:0]                    m1_rd_idx,
    input  mem_pipe_pkg::word_t           mem_rdata,

    output logic                          wr_en,
    output logic [`MEM_PIPE_ADDR_W-1:0]   wr_addr,
    output mem_pipe_pkg::word_t           wr_data,

    output logic                          wb_valid,
    output logic [4:0]                    wb_rd_idx,
    output logic                          wb_rd_we,
    output mem_pipe_pkg::word_t           wb_data
);

    import mem_pipe_pkg::*;

    logic                        m2_valid;
    mem_op_e                     m2_mem_op;
    amo_op_e                     m2_amo_op;
    logic [`MEM_PIPE_ADDR_W-1:0] m2_addr;
    word_t                       m2_rs2_val;
    logic [4:0]                  m2_rd_idx;

    logic  rdata_held;  // set while the memory word below belongs to this op
    word_t rdata_hold;
    word_t load_word;
    word_t amo_result;
    logic  out_valid;
    logic  is_write;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            m2_valid   <= 1'b0;
            rdata_held <= 1'b0;
        end else begin
            if (!stall) begin
                m2_valid <= m1_valid;
            end else if (flush) begin
                m2_valid <= 1'b0; // a flushed op does not return once the stall ends
            end
            rdata_held <= stall; // memory keeps reading ahead while we stall
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            m2_mem_op  <= m1_mem_op;
            m2_amo_op  <= m1_amo_op;
            m2_addr    <= m1_addr;
            m2_rs2_val <= m1_rs2_val;
            m2_rd_idx  <= m1_rd_idx;
        end else begin
            rdata_hold <= load_word; // keep this op's word across the stall
        end
    end

    // During a stall the memory read port has already moved on to the stage 1
    // address, so the word captured on the first stalled edge is used instead.
    assign load_word = rdata_held ? rdata_hold : mem_rdata;

    always_comb begin
        case (m2_amo_op)
            AMO_OP_SWAP: amo_result = m2_rs2_val;
            AMO_OP_ADD:  amo_result = load_word + m2_rs2_val;
            AMO_OP_AND:  amo_result = load_word & m2_rs2_val;
            AMO_OP_OR:   amo_result = load_word | m2_rs2_val;
            AMO_OP_XOR:  amo_result = load_word ^ m2_rs2_val;
            AMO_OP_MIN:  amo_result = ($signed(load_word) < $signed(m2_rs2_val))
                                      ? load_word : m2_rs2_val;
            AMO_OP_MAX:  amo_result = ($signed(load_word) > $signed(m2_rs2_val))
                                      ? load_word : m2_rs2_val;
            AMO_OP_MINU: amo_result = (load_word < m2_rs2_val) ? load_word : m2_rs2_val;
            AMO_OP_MAXU: amo_result = (load_word > m2_rs2_val) ? load_word : m2_rs2_val;
            default:     amo_result = m2_rs2_val; // unused encodings behave as swap
        endcase
    end

    assign out_valid = m2_valid && !flush && !stall; // flushed ops simply vanish
    assign is_write  = (m2_mem_op == MEM_OP_STORE) || (m2_mem_op == MEM_OP_AMO);

    // memory write for stores and AMOs
    assign wr_en   = out_valid && is_write;
    assign wr_addr = m2_addr;
    assign wr_data = (m2_mem_op == MEM_OP_AMO) ? amo_result : m2_rs2_val;

    // register write-back where x0 is never written
    assign wb_valid  = out_valid;
    assign wb_rd_idx = m2_rd_idx;
    assign wb_rd_we  = (m2_mem_op != MEM_OP_STORE) && (m2_rd_idx != 5'd0);
    assign wb_data   = (m2_mem_op == MEM_OP_STORE) ? '0 : load_word; // AMO returns old word

endmodule : stage_memory2

//--- hw/data_mem.sv
// Data word memory
`timescale 1ns/1ps
`include "mem_pipe_consts.svh"

module data_mem (
    input  logic                          clk,
    input  logic [`MEM_PIPE_ADDR_W-1:0]   rd_addr,
    input  logic                          wr_en,
    input  logic [`MEM_PIPE_ADDR_W-1:0]   wr_addr,
    input  mem_pipe_pkg::word_t           wr_data,
    output mem_pipe_pkg::word_t           rd_data
);

    import mem_pipe_pkg::*;

    word_t mem_array [`MEM_PIPE_DEPTH]; // contents are preloaded from outside

    logic fwd_hit;

    // a write and a read of the same word in one cycle
    assign fwd_hit = wr_en && (wr_addr == rd_addr);

    // write port
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem_array[wr_addr] <= wr_data;
        end
    end

    // Registered read port. On an address match the new write data is
    // returned, which lets an AMO directly behind another AMO to the same
    // word see the updated value.
    always_ff @(posedge clk) begin
        if (fwd_hit) begin
            rd_data <= wr_data;
        end else begin
            rd_data <= mem_array[rd_addr];
        end
    end

endmodule : data_mem

//--- hw/stage_memory1.sv
// Memory stage 1
`timescale 1ns/1ps
`include "mem_pipe_consts.svh"

module stage_memory1 (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          stall,

    input  logic                          in_valid,
    input  mem_pipe_pkg::mem_op_e         in_mem_op,
    input  mem_pipe_pkg::amo_op_e         in_amo_op,
    input  logic [`MEM_PIPE_ADDR_W-1:0]   in_addr,
    input  mem_pipe_pkg::word_t           in_rs2_val,
    input  logic [4:0]                    in_rd_idx,

    output logic                          m1_valid,
    output mem_pipe_pkg::mem_op_e         m1_mem_op,
    output mem_pipe_pkg::amo_op_e         m1_amo_op,
    output logic [`MEM_PIPE_ADDR_W-1:0]   m1_addr,
    output mem_pipe_pkg::word_t           m1_rs2_val,
    output logic [4:0]                    m1_rd_idx,

    output logic [`MEM_PIPE_ADDR_W-1:0]   rd_addr
);

    // the valid bit is the only control state in this stage
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            m1_valid <= 1'b0;
        end else if (!stall) begin
            m1_valid <= in_valid; // an op is accepted when not stalled
        end
    end

    // payload follows the input whenever the pipe advances
    always_ff @(posedge clk) begin
        if (!stall) begin
            m1_mem_op  <= in_mem_op;
            m1_amo_op  <= in_amo_op;
            m1_addr    <= in_addr;
            m1_rs2_val <= in_rs2_val;
            m1_rd_idx  <= in_rd_idx;
        end
    end

    // The memory samples this address at the same edge that moves the op into
    // stage 2, so the read data arrives together with the op.
    assign rd_addr = m1_addr;

endmodule : stage_memory1

//--- hw/mem_pipe_pkg.sv
// Memory pipeline types
`include "mem_pipe_consts.svh"

package mem_pipe_pkg;

    typedef logic [`MEM_PIPE_XLEN-1:0] word_t; // one data word

    // kind of memory operation
    typedef enum logic [1:0] {
        MEM_OP_LOAD  = 2'd0,
        MEM_OP_STORE = 2'd1,
        MEM_OP_AMO   = 2'd2
    } mem_op_e;

    // AMO function, ignored unless the op is an AMO
    typedef enum logic [3:0] {
        AMO_OP_SWAP = 4'd0,
        AMO_OP_ADD  = 4'd1,
        AMO_OP_AND  = 4'd2,
        AMO_OP_OR   = 4'd3,
        AMO_OP_XOR  = 4'd4,
        AMO_OP_MIN  = 4'd5,
        AMO_OP_MAX  = 4'd6,
        AMO_OP_MINU = 4'd7,
        AMO_OP_MAXU = 4'd8
    } amo_op_e;

endpackage : mem_pipe_pkg

//--- hw/mem_pipe_consts.svh
// Memory pipeline constants
`ifndef MEM_PIPE_CONSTS_SVH
`define MEM_PIPE_CONSTS_SVH

// data word width in bits
`define MEM_PIPE_XLEN 32

// word address width and the resulting number of words
`define MEM_PIPE_ADDR_W 6
`define MEM_PIPE_DEPTH (1 << `MEM_PIPE_ADDR_W)

`endif
